/* common/cache_pkg.sv */
package cache_pkg;

  //////////////////////////////////////////////////
  // Widths and cache geometry
  //////////////////////////////////////////////////
  localparam int WORD_W      = 16;                        // Data word
  localparam int ADDR_W      = 16;                        // Word address
  localparam int OFFSET_W    = 3;                         // Word within a block
  localparam int INDEX_W     = 5;                         // Set select
  localparam int TAG_W       = ADDR_W - INDEX_W - OFFSET_W; // Upper address bits
  localparam int SETS        = 1 << INDEX_W;              // 32 sets
  localparam int BLOCK_WORDS = 1 << OFFSET_W;             // 8 words per block

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////
  typedef logic [WORD_W-1:0]   word_t;                    // One data word
  typedef logic [ADDR_W-1:0]   addr_t;                    // One word address
  typedef logic [TAG_W-1:0]    tag_t;                     // Address tag, top bits
  typedef logic [INDEX_W-1:0]  index_t;                   // Set index, middle bits
  typedef logic [OFFSET_W-1:0] offset_t;                  // Block offset, bottom bits

  // Miss handler states
  typedef enum logic [1:0] {
    IDLE,                                                 // Waiting for a miss
    FILL,                                                 // Issuing reads, collecting words
    DONE                                                  // Block written, one cycle gap
  } fill_state_e;

endpackage

/* cache/cache_array.sv */
module cache_array (
  input  logic               clk,
  input  logic               arst_n,
  input  cache_pkg::addr_t   rd_addr,      // Lookup address, also selects the fill set
  input  logic               fill_we,      // Write one returning block word
  input  cache_pkg::offset_t fill_offset,  // Word slot for the fill write
  input  cache_pkg::word_t   fill_word,    // Word from memory
  input  logic               fill_last,    // Final word of the block
  input  logic               store_we,     // Store hit write
  input  cache_pkg::word_t   store_word,   // Store data
  output cache_pkg::word_t   rd_word,      // Addressed word, asynchronous read
  output logic               hit           // Valid and tag match
);

  cache_pkg::tag_t            tag_q   [cache_pkg::SETS];                          // Tag per set
  logic [cache_pkg::SETS-1:0] valid_q;                                            // Valid per set
  cache_pkg::word_t           data_q  [cache_pkg::SETS * cache_pkg::BLOCK_WORDS]; // Block words

  cache_pkg::tag_t    req_tag;
  cache_pkg::index_t  req_index;
  cache_pkg::offset_t req_offset;

  // Split the word address into tag, index and offset
  assign req_tag    = rd_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
  assign req_index  = rd_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
  assign req_offset = rd_addr[cache_pkg::OFFSET_W-1:0];

  //////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////
  assign rd_word = data_q[{req_index, req_offset}];                 // Word of the addressed set
  assign hit     = valid_q[req_index] && (tag_q[req_index] == req_tag);

  //////////////////////////////////////////////////
  // Valid bits
  //////////////////////////////////////////////////
  // First fill word drops the old block, last one marks the new block valid
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;                                                // Empty cache after reset
    end else if (fill_we) begin
      valid_q[req_index] <= fill_last;
    end
  end

  //////////////////////////////////////////////////
  // Tag and data storage
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (fill_we) begin
      data_q[{req_index, fill_offset}] <= fill_word;               // Word in fill order
      if (fill_last) begin
        tag_q[req_index] <= req_tag;                               // Block now owned by this tag
      end
    end else if (store_we) begin
      data_q[{req_index, req_offset}] <= store_word;               // Store hit update
    end
  end

endmodule

/* cache/fill_fsm.sv */
module fill_fsm (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               miss,            // Request present without a hit
  input  cache_pkg::addr_t   miss_addr,       // Held request address
  input  logic               grant,           // Bus owned by this cache
  input  logic               issue_ok,        // No write-through this cycle
  input  logic               mem_data_valid,  // Read data strobe from memory
  input  cache_pkg::word_t   mem_data_in,     // Read data
  output logic               fill_req,        // Bus request while filling
  output cache_pkg::addr_t   fill_addr,       // Next block read address
  output logic               fill_issue,      // Read issued this cycle
  output logic               fill_we,         // Array word write
  output cache_pkg::offset_t fill_offset,     // Slot of the returning word
  output cache_pkg::word_t   fill_word,       // Returning word
  output logic               fill_last,       // Eighth word of the block
  output logic               busy             // Miss in progress
);

  cache_pkg::fill_state_e       state_q;
  cache_pkg::fill_state_e       state_d;
  logic [cache_pkg::OFFSET_W:0] issue_cnt_q;  // Reads issued so far, 0 to 8
  cache_pkg::offset_t           rx_cnt_q;     // Words received so far
  logic                         issue_done;   // All block reads sent

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////
  assign fill_req    = (state_q == cache_pkg::FILL);  // Hold the bus until the last word
  assign busy        = fill_req;
  assign issue_done  = (issue_cnt_q == (cache_pkg::OFFSET_W + 1)'(cache_pkg::BLOCK_WORDS));
  assign fill_issue  = fill_req && grant && issue_ok && !issue_done;
  assign fill_addr   = {miss_addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W],
                        issue_cnt_q[cache_pkg::OFFSET_W-1:0]};  // Block base plus word count

  // Reads come back in order, so the receive count is the word slot
  assign fill_we     = fill_req && grant && mem_data_valid;
  assign fill_offset = rx_cnt_q;
  assign fill_word   = mem_data_in;
  assign fill_last   = fill_we && (rx_cnt_q == cache_pkg::OFFSET_W'(cache_pkg::BLOCK_WORDS - 1));

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      cache_pkg::IDLE: begin
        if (miss) begin
          state_d = cache_pkg::FILL;                  // Busy from the next edge
        end
      end
      cache_pkg::FILL: begin
        if (fill_last) begin
          state_d = cache_pkg::DONE;                  // Tag and valid land at this edge
        end
      end
      cache_pkg::DONE: state_d = cache_pkg::IDLE;     // Request hits here
      default:         state_d = cache_pkg::IDLE;
    endcase
  end

  //////////////////////////////////////////////////
  // State and counters
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q     <= cache_pkg::IDLE;
      issue_cnt_q <= '0;
      rx_cnt_q    <= '0;
    end else begin
      state_q <= state_d;
      if (state_q != cache_pkg::FILL) begin
        issue_cnt_q <= '0;                            // Fresh block on every fill
        rx_cnt_q    <= '0;
      end else begin
        if (fill_issue) begin
          issue_cnt_q <= issue_cnt_q + 1'b1;
        end
        if (fill_we) begin
          rx_cnt_q <= rx_cnt_q + 1'b1;                // Wraps to zero on the last word
        end
      end
    end
  end

endmodule

/* cache/icache.sv */
module icache (
  input  logic             clk,
  input  logic             arst_n,
  input  cache_pkg::addr_t fetch_addr,      // Fetch address, always present
  input  logic             i_grant,         // Bus owned by the instruction side
  input  logic             issue_ok,        // No write-through this cycle
  input  logic             mem_data_valid,  // Broadcast read strobe
  input  cache_pkg::word_t mem_data_in,     // Broadcast read data
  output cache_pkg::word_t instr,           // Fetched word
  output logic             instr_hit,       // Fetch served this cycle
  output logic             i_fill_req,      // Bus request
  output cache_pkg::addr_t i_fill_addr,     // Block read address
  output logic             i_fill_issue,    // Read issued this cycle
  output logic             icache_busy      // Miss in progress
);

  logic               fill_we;
  cache_pkg::offset_t fill_offset;
  cache_pkg::word_t   fill_word;
  logic               fill_last;

  // Read-only side, so the store port never fires
  cache_array u_array (
    .clk        (clk),
    .arst_n     (arst_n),
    .rd_addr    (fetch_addr),
    .fill_we    (fill_we),
    .fill_offset(fill_offset),
    .fill_word  (fill_word),
    .fill_last  (fill_last),
    .store_we   (1'b0),
    .store_word ('0),
    .rd_word    (instr),
    .hit        (instr_hit)
  );

  fill_fsm u_fill (
    .clk           (clk),
    .arst_n        (arst_n),
    .miss          (!instr_hit),                  // Every fetch is a request
    .miss_addr     (fetch_addr),
    .grant         (i_grant),
    .issue_ok      (issue_ok),
    .mem_data_valid(mem_data_valid),
    .mem_data_in   (mem_data_in),
    .fill_req      (i_fill_req),
    .fill_addr     (i_fill_addr),
    .fill_issue    (i_fill_issue),
    .fill_we       (fill_we),
    .fill_offset   (fill_offset),
    .fill_word     (fill_word),
    .fill_last     (fill_last),
    .busy          (icache_busy)
  );

endmodule

/* cache/dcache.sv */
module dcache (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             data_en,         // Load or store request
  input  logic             data_wr,         // Store when high
  input  cache_pkg::addr_t data_addr,       // Word address of the access
  input  cache_pkg::word_t data_wdata,      // Store data
  input  logic             d_grant,         // Bus owned by the data side
  input  logic             issue_ok,        // No write-through this cycle
  input  logic             mem_data_valid,  // Broadcast read strobe
  input  cache_pkg::word_t mem_data_in,     // Broadcast read data
  output cache_pkg::word_t data_rdata,      // Load data
  output logic             data_hit,        // Access served this cycle
  output logic             d_fill_req,      // Bus request
  output cache_pkg::addr_t d_fill_addr,     // Block read address
  output logic             d_fill_issue,    // Read issued this cycle
  output logic             wt_req,          // Write-through request
  output cache_pkg::addr_t wt_addr,         // Write-through address
  output cache_pkg::word_t wt_data,         // Write-through data
  output logic             dcache_busy      // Miss in progress
);

  logic               array_hit;
  logic               fill_we;
  cache_pkg::offset_t fill_offset;
  cache_pkg::word_t   fill_word;
  logic               fill_last;

  //////////////////////////////////////////////////
  // Hit and store path
  //////////////////////////////////////////////////
  assign data_hit = data_en && array_hit;
  assign wt_req   = data_hit && data_wr;        // One write per store-hit cycle
  assign wt_addr  = data_addr;
  assign wt_data  = data_wdata;

  cache_array u_array (
    .clk        (clk),
    .arst_n     (arst_n),
    .rd_addr    (data_addr),
    .fill_we    (fill_we),
    .fill_offset(fill_offset),
    .fill_word  (fill_word),
    .fill_last  (fill_last),
    .store_we   (wt_req),                       // Array and memory updated together
    .store_word (data_wdata),
    .rd_word    (data_rdata),
    .hit        (array_hit)
  );

  // Loads and stores both allocate on a miss
  fill_fsm u_fill (
    .clk           (clk),
    .arst_n        (arst_n),
    .miss          (data_en && !array_hit),
    .miss_addr     (data_addr),
    .grant         (d_grant),
    .issue_ok      (issue_ok),
    .mem_data_valid(mem_data_valid),
    .mem_data_in   (mem_data_in),
    .fill_req      (d_fill_req),
    .fill_addr     (d_fill_addr),
    .fill_issue    (d_fill_issue),
    .fill_we       (fill_we),
    .fill_offset   (fill_offset),
    .fill_word     (fill_word),
    .fill_last     (fill_last),
    .busy          (dcache_busy)
  );

endmodule

/* logic/mem_arbiter.sv */
module mem_arbiter (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             i_fill_req,    // Instruction side wants the bus
  input  cache_pkg::addr_t i_fill_addr,
  input  logic             i_fill_issue,
  input  logic             d_fill_req,    // Data side wants the bus
  input  cache_pkg::addr_t d_fill_addr,
  input  logic             d_fill_issue,
  input  logic             wt_req,        // Store hit going through to memory
  input  cache_pkg::addr_t wt_addr,
  input  cache_pkg::word_t wt_data,
  output logic             i_grant,
  output logic             d_grant,
  output logic             issue_ok,      // Fill reads allowed this cycle
  output logic             mem_en,
  output cache_pkg::addr_t mem_addr,
  output logic             mem_wr,
  output cache_pkg::word_t mem_data_out
);

  logic i_own_q;   // Instruction side held the bus last cycle
  logic d_own_q;   // Data side held the bus last cycle
  logic keep_i;
  logic keep_d;

  //////////////////////////////////////////////////
  // Grant
  //////////////////////////////////////////////////
  // Owner stays until its request drops, then data side goes first
  assign keep_i  = i_own_q && i_fill_req;
  assign keep_d  = d_own_q && d_fill_req;
  assign d_grant = keep_d || (!keep_i && d_fill_req);
  assign i_grant = keep_i || (!keep_d && !d_fill_req && i_fill_req);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      i_own_q <= 1'b0;
      d_own_q <= 1'b0;
    end else begin
      i_own_q <= i_grant;
      d_own_q <= d_grant;
    end
  end

  //////////////////////////////////////////////////
  // Memory port
  //////////////////////////////////////////////////
  // Write-through steals the cycle, grant stays so returning words still land
  assign issue_ok     = !wt_req;
  assign mem_en       = wt_req || (d_grant && d_fill_issue) || (i_grant && i_fill_issue);
  assign mem_wr       = wt_req;
  assign mem_addr     = wt_req  ? wt_addr     :
                        d_grant ? d_fill_addr :
                        i_grant ? i_fill_addr :
                        '0;
  assign mem_data_out = wt_data;                  // Only sampled on a write

endmodule

/* logic/mem_hier.sv */
module mem_hier (
  input  logic             clk,
  input  logic             arst_n,
  input  cache_pkg::addr_t fetch_addr,      // Instruction fetch address
  input  logic             data_en,         // Data access request
  input  logic             data_wr,         // Store when high
  input  cache_pkg::addr_t data_addr,
  input  cache_pkg::word_t data_wdata,
  input  logic             mem_data_valid,  // Off-chip read strobe
  input  cache_pkg::word_t mem_data_in,     // Off-chip read data
  output cache_pkg::word_t instr,
  output logic             instr_hit,
  output logic             icache_busy,
  output cache_pkg::word_t data_rdata,
  output logic             data_hit,
  output logic             dcache_busy,
  output logic             mem_en,          // One cycle per read or write
  output cache_pkg::addr_t mem_addr,
  output logic             mem_wr,
  output cache_pkg::word_t mem_data_out
);

  //////////////////////////////////////////////////
  // Cache to arbiter wiring
  //////////////////////////////////////////////////
  logic             i_fill_req;
  cache_pkg::addr_t i_fill_addr;
  logic             i_fill_issue;
  logic             i_grant;
  logic             d_fill_req;
  cache_pkg::addr_t d_fill_addr;
  logic             d_fill_issue;
  logic             d_grant;
  logic             wt_req;
  cache_pkg::addr_t wt_addr;
  cache_pkg::word_t wt_data;
  logic             issue_ok;        // Shared back-pressure from write-through

  icache u_icache (
    .clk           (clk),
    .arst_n        (arst_n),
    .fetch_addr    (fetch_addr),
    .i_grant       (i_grant),
    .issue_ok      (issue_ok),
    .mem_data_valid(mem_data_valid),
    .mem_data_in   (mem_data_in),
    .instr         (instr),
    .instr_hit     (instr_hit),
    .i_fill_req    (i_fill_req),
    .i_fill_addr   (i_fill_addr),
    .i_fill_issue  (i_fill_issue),
    .icache_busy   (icache_busy)
  );

  dcache u_dcache (
    .clk           (clk),
    .arst_n        (arst_n),
    .data_en       (data_en),
    .data_wr       (data_wr),
    .data_addr     (data_addr),
    .data_wdata    (data_wdata),
    .d_grant       (d_grant),
    .issue_ok      (issue_ok),
    .mem_data_valid(mem_data_valid),
    .mem_data_in   (mem_data_in),
    .data_rdata    (data_rdata),
    .data_hit      (data_hit),
    .d_fill_req    (d_fill_req),
    .d_fill_addr   (d_fill_addr),
    .d_fill_issue  (d_fill_issue),
    .wt_req        (wt_req),
    .wt_addr       (wt_addr),
    .wt_data       (wt_data),
    .dcache_busy   (dcache_busy)
  );

  // Single off-chip port shared by both caches
  mem_arbiter u_arbiter (
    .clk         (clk),
    .arst_n      (arst_n),
    .i_fill_req  (i_fill_req),
    .i_fill_addr (i_fill_addr),
    .i_fill_issue(i_fill_issue),
    .d_fill_req  (d_fill_req),
    .d_fill_addr (d_fill_addr),
    .d_fill_issue(d_fill_issue),
    .wt_req      (wt_req),
    .wt_addr     (wt_addr),
    .wt_data     (wt_data),
    .i_grant     (i_grant),
    .d_grant     (d_grant),
    .issue_ok    (issue_ok),
    .mem_en      (mem_en),
    .mem_addr    (mem_addr),
    .mem_wr      (mem_wr),
    .mem_data_out(mem_data_out)
  );

endmodule

/* sim/mem_model.sv */
module mem_model (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             mem_en,          // One cycle per access
  input  logic             mem_wr,          // Write when high
  input  cache_pkg::addr_t mem_addr,
  input  cache_pkg::word_t mem_data_out,    // Write data from the DUT
  output logic             mem_data_valid,  // One pulse per returned read
  output cache_pkg::word_t mem_data_in      // Read data
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MEM_LATENCY = 4;                   // Cycles from issue to data
  localparam int DEPTH       = 1 << cache_pkg::ADDR_W;

  cache_pkg::word_t       mem [DEPTH];              // Whole word address space
  logic [MEM_LATENCY-1:0] pipe_valid;               // Reads in flight
  cache_pkg::word_t       pipe_data [MEM_LATENCY];

  // Same fill pattern the testbench starts its shadow from
  function automatic cache_pkg::word_t init_word(input cache_pkg::addr_t addr);
    cache_pkg::word_t mixed;
    mixed = addr * 16'h9e37;                        // Odd multiplier, every bit counts
    return mixed ^ 16'hc3a5;
  endfunction

  initial begin
    for (int a = 0; a < DEPTH; a++) begin
      mem[a] = init_word(cache_pkg::addr_t'(a));
    end
  end

  //////////////////////////////////////////////////
  // Fixed latency read pipe, in order
  //////////////////////////////////////////////////
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pipe_valid <= '0;                             // Nothing in flight
    end else begin
      pipe_valid   <= {pipe_valid[MEM_LATENCY-2:0], mem_en && !mem_wr};
      pipe_data[0] <= mem[mem_addr];                // Read before a same-cycle write
      for (int i = 1; i < MEM_LATENCY; i++) begin
        pipe_data[i] <= pipe_data[i-1];
      end
      if (mem_en && mem_wr) begin
        mem[mem_addr] <= mem_data_out;              // Write-through lands here
      end
    end
  end

  assign mem_data_valid = pipe_valid[MEM_LATENCY-1];
  assign mem_data_in    = pipe_data[MEM_LATENCY-1];

endmodule

/* sim/tb_mem_hier.sv */
module tb_mem_hier;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 200;                  // Cycles allowed for any one wait

  logic             clk;
  logic             arst_n;
  cache_pkg::addr_t fetch_addr;
  logic             data_en;
  logic             data_wr;
  cache_pkg::addr_t data_addr;
  cache_pkg::word_t data_wdata;
  logic             mem_data_valid;
  cache_pkg::word_t mem_data_in;
  cache_pkg::word_t instr;
  logic             instr_hit;
  logic             icache_busy;
  cache_pkg::word_t data_rdata;
  logic             data_hit;
  logic             dcache_busy;
  logic             mem_en;
  cache_pkg::addr_t mem_addr;
  logic             mem_wr;
  cache_pkg::word_t mem_data_out;

  cache_pkg::word_t shadow [1 << cache_pkg::ADDR_W];  // Expected memory image
  string            cur_test;
  int               checks;
  int               errors;
  int               test_err0;                      // Error count at test start
  logic             track_reads;                    // Read address check active
  cache_pkg::addr_t blk_i;                          // Block asked for by icache
  cache_pkg::addr_t blk_d;                          // Block asked for by dcache

  mem_hier uut (
    .clk           (clk),
    .arst_n        (arst_n),
    .fetch_addr    (fetch_addr),
    .data_en       (data_en),
    .data_wr       (data_wr),
    .data_addr     (data_addr),
    .data_wdata    (data_wdata),
    .mem_data_valid(mem_data_valid),
    .mem_data_in   (mem_data_in),
    .instr         (instr),
    .instr_hit     (instr_hit),
    .icache_busy   (icache_busy),
    .data_rdata    (data_rdata),
    .data_hit      (data_hit),
    .dcache_busy   (dcache_busy),
    .mem_en        (mem_en),
    .mem_addr      (mem_addr),
    .mem_wr        (mem_wr),
    .mem_data_out  (mem_data_out)
  );

  mem_model u_mem (
    .clk           (clk),
    .arst_n        (arst_n),
    .mem_en        (mem_en),
    .mem_wr        (mem_wr),
    .mem_addr      (mem_addr),
    .mem_data_out  (mem_data_out),
    .mem_data_valid(mem_data_valid),
    .mem_data_in   (mem_data_in)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;                            // 20 ns period

  //////////////////////////////////////////////////
  // Reference and helpers
  //////////////////////////////////////////////////
  function automatic cache_pkg::word_t init_word(input cache_pkg::addr_t addr);
    cache_pkg::word_t mixed;
    mixed = addr * 16'h9e37;                        // Odd multiplier spreads every address bit
    return mixed ^ 16'hc3a5;
  endfunction

  // Top address bit picks the code or data space so stores never touch fetched blocks
  function automatic cache_pkg::addr_t rand_addr(input logic region);
    logic [31:0] r;
    r = $urandom;
    return {region, r[cache_pkg::ADDR_W-2:0]};
  endfunction

  function automatic cache_pkg::word_t rand_word();
    logic [31:0] r;
    r = $urandom;
    return r[cache_pkg::WORD_W-1:0];
  endfunction

  function automatic logic same_block(input cache_pkg::addr_t a, input cache_pkg::addr_t b);
    return a[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W] == b[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W];
  endfunction

  task automatic check_word(input string name, input cache_pkg::word_t exp,
                            input cache_pkg::word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s %s: expected %h, actual %h", cur_test, name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input cache_pkg::addr_t exp,
                            input cache_pkg::addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s %s: expected %h, actual %h", cur_test, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s %s: expected %b, actual %b", cur_test, name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("TIMEOUT in %s: %s did not happen within %0d cycles", cur_test, what, WAIT_LIMIT);
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_err0 = errors;
  endtask

  task automatic end_test;
    $display("test %s finished with %0d errors", cur_test, errors - test_err0);
  endtask

  //////////////////////////////////////////////////
  // Bounded waits
  //////////////////////////////////////////////////
  task automatic wait_data_hit(output logic ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < WAIT_LIMIT) begin
      @(posedge clk);
      ok = data_hit;
      n++;
    end
    if (!ok) report_timeout("a data hit");
  endtask

  task automatic wait_ibusy(input logic level, output logic ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < WAIT_LIMIT) begin
      @(posedge clk);
      ok = (icache_busy === level);
      n++;
    end
    if (!ok) report_timeout(level ? "icache_busy rising" : "icache_busy falling");
  endtask

  //////////////////////////////////////////////////
  // Data side accesses
  //////////////////////////////////////////////////
  task automatic load_word(input cache_pkg::addr_t addr, output cache_pkg::word_t value,
                           output logic first_hit);
    logic ok;
    @(negedge clk);
    data_en   = 1'b1;
    data_wr   = 1'b0;
    data_addr = addr;
    @(posedge clk);
    first_hit = data_hit;                           // Hit or miss on first sight
    ok        = data_hit;
    if (!ok) begin
      @(posedge clk);
      check_bit("dcache_busy after miss", 1'b1, dcache_busy);  // Rises at the miss edge
      wait_data_hit(ok);
    end
    if (ok) check_bit("dcache_busy at hit", 1'b0, dcache_busy);
    value = data_rdata;
    @(negedge clk);
    data_en = 1'b0;
  endtask

  task automatic store_word(input cache_pkg::addr_t addr, input cache_pkg::word_t value,
                            output logic first_hit);
    logic ok;
    @(negedge clk);
    data_en    = 1'b1;
    data_wr    = 1'b1;
    data_addr  = addr;
    data_wdata = value;
    @(posedge clk);
    first_hit = data_hit;
    ok        = data_hit;
    if (!ok) wait_data_hit(ok);                     // Store miss fills first
    if (ok) begin
      check_bit("store mem_en", 1'b1, mem_en);      // Write-through in the hit cycle
      check_bit("store mem_wr", 1'b1, mem_wr);
      check_addr("store mem_addr", addr, mem_addr);
      check_word("store mem_data_out", value, mem_data_out);
    end
    @(negedge clk);
    data_en = 1'b0;                                 // One write per store hit
    data_wr = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////
  always @(posedge clk) begin
    if (arst_n) begin
      if (instr_hit) check_word("instr vs shadow", shadow[fetch_addr], instr);
      if (data_hit && !data_wr) check_word("load vs shadow", shadow[data_addr], data_rdata);
      if (track_reads && mem_en && !mem_wr &&
          !same_block(mem_addr, blk_i) && !same_block(mem_addr, blk_d)) begin
        errors++;
        $display("ERROR in %s: memory read of %h is outside both requested blocks",
                 cur_test, mem_addr);
      end
      if (mem_en && mem_wr) shadow[mem_addr] = mem_data_out;  // Observed write-through
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  initial begin
    cache_pkg::addr_t ia;
    cache_pkg::addr_t ic;
    cache_pkg::addr_t a;
    cache_pkg::addr_t a2;
    cache_pkg::addr_t b;
    cache_pkg::addr_t dd;
    cache_pkg::word_t val;
    cache_pkg::word_t d;
    cache_pkg::word_t d2;
    cache_pkg::word_t iv;
    cache_pkg::word_t dv;
    logic             fh;
    logic             ok;
    logic             got_i;
    logic             got_d;
    int               n;

    void'($urandom(32'h2269));                      // Single seed for the run
    checks      = 0;
    errors      = 0;
    track_reads = 1'b0;
    blk_i       = '0;
    blk_d       = '0;
    ia          = rand_addr(1'b0);
    arst_n      = 1'b0;
    fetch_addr  = ia;                               // Held until it hits
    data_en     = 1'b0;
    data_wr     = 1'b0;
    data_addr   = '0;
    data_wdata  = '0;
    for (int i = 0; i < (1 << cache_pkg::ADDR_W); i++) begin
      shadow[i] = init_word(cache_pkg::addr_t'(i));
    end
    repeat (2) @(negedge clk);
    arst_n = 1'b1;

    begin_test("reset");
    @(posedge clk);
    check_bit("mem_en", 1'b0, mem_en);
    check_bit("mem_wr", 1'b0, mem_wr);
    check_bit("icache_busy", 1'b0, icache_busy);
    check_bit("dcache_busy", 1'b0, dcache_busy);
    check_bit("first fetch", 1'b0, instr_hit);      // Empty cache
    end_test();

    begin_test("imiss");
    wait_ibusy(1'b1, ok);
    wait_ibusy(1'b0, ok);
    check_bit("hit after fill", 1'b1, instr_hit);
    check_word("fetched word", init_word(ia), instr);
    for (int k = 0; k < cache_pkg::BLOCK_WORDS; k++) begin
      @(negedge clk);
      fetch_addr = {ia[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W], cache_pkg::offset_t'(k)};
      @(posedge clk);
      check_bit("block word hit", 1'b1, instr_hit);
      check_word("block word", init_word(fetch_addr), instr);
    end
    end_test();

    begin_test("dload");
    for (int k = 0; k < 4; k++) begin
      a = rand_addr(1'b1);
      load_word(a, val, fh);
      check_word("load", init_word(a), val);
      load_word(a, val, fh);
      check_bit("reload hit", 1'b1, fh);
    end
    a  = rand_addr(1'b1);
    a2 = a ^ 16'h4000;                              // Flips a tag bit and keeps the index
    load_word(a, val, fh);
    load_word(a2, val, fh);
    check_bit("evicting miss", 1'b0, fh);
    check_word("evicting load", init_word(a2), val);
    load_word(a, val, fh);
    check_bit("evicted miss", 1'b0, fh);
    check_word("evicted load", init_word(a), val);
    end_test();

    begin_test("store");
    a = rand_addr(1'b1);
    load_word(a, val, fh);
    d = rand_word();
    store_word(a, d, fh);
    check_bit("store hit", 1'b1, fh);
    load_word(a, val, fh);
    check_bit("load after store hit", 1'b1, fh);
    check_word("load after store", d, val);
    b  = a ^ 16'h0100;                              // Evicts a's block
    d2 = rand_word();
    store_word(b, d2, fh);
    check_bit("store miss", 1'b0, fh);
    load_word(b, val, fh);
    check_word("load after store miss", d2, val);
    load_word(b ^ 16'h0001, val, fh);
    check_bit("neighbour hit", 1'b1, fh);
    check_word("neighbour word", init_word(b ^ 16'h0001), val);
    load_word(a, val, fh);
    check_bit("refill miss", 1'b0, fh);
    check_word("refill from memory", d, val);       // Came back through memory
    end_test();

    begin_test("dual");
    ic = rand_addr(1'b0);
    if (same_block(ic, fetch_addr)) ic = ic ^ 16'h0100;
    dd = (a ^ 16'h0200) ^ (rand_word() & 16'h0007);  // Fresh tag in the set of a
    blk_i = ic;
    blk_d = dd;
    @(negedge clk);
    track_reads = 1'b1;
    fetch_addr  = ic;
    data_en     = 1'b1;
    data_wr     = 1'b0;
    data_addr   = dd;
    got_i = 1'b0;
    got_d = 1'b0;
    n     = 0;
    while (!(got_i && got_d) && n < 2 * WAIT_LIMIT) begin
      @(posedge clk);
      if (n == 0) begin
        check_bit("instr miss", 1'b0, instr_hit);
        check_bit("data miss", 1'b0, data_hit);
      end
      if (instr_hit && !got_i) begin
        got_i = 1'b1;
        iv    = instr;
      end
      if (data_hit && !got_d) begin
        got_d = 1'b1;
        dv    = data_rdata;
      end
      n++;
    end
    if (!(got_i && got_d)) begin
      errors++;
      $display("TIMEOUT in %s: both fills did not complete within %0d cycles",
               cur_test, 2 * WAIT_LIMIT);
    end else begin
      check_word("dual instr", init_word(ic), iv);
      check_word("dual data", init_word(dd), dv);
    end
    @(negedge clk);
    data_en     = 1'b0;
    track_reads = 1'b0;
    @(posedge clk);
    check_bit("icache idle", 1'b0, icache_busy);
    check_bit("dcache idle", 1'b0, dcache_busy);
    end_test();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* flist.f */
common/cache_pkg.sv
cache/cache_array.sv
cache/fill_fsm.sv
cache/icache.sv
cache/dcache.sv
logic/mem_arbiter.sv
logic/mem_hier.sv
sim/mem_model.sv
sim/tb_mem_hier.sv

/* Bender.yml */
package:
  name: mem_hier

sources:
  - common/cache_pkg.sv
  - cache/cache_array.sv
  - cache/fill_fsm.sv
  - cache/icache.sv
  - cache/dcache.sv
  - logic/mem_arbiter.sv
  - logic/mem_hier.sv
  - target: simulation
    files:
      - sim/mem_model.sv
      - sim/tb_mem_hier.sv
